// ==== src.f ====
hdl/mm_sched_pkg.sv
hdl/sched_config.sv
hdl/x_iter_ctrl.sv
hdl/w_iter_ctrl.sv
hdl/sched_fsm.sv
hdl/z_drain_ctrl.sv
hdl/mm_scheduler.sv
verif/tb_mm_scheduler.sv

// ==== verif/tb_mm_scheduler.sv ====
// Self-checking testbench for the matrix-multiply scheduler
// Models the X and Z buffer flags, runs a set of jobs and checks the DUT with assertions

`timescale 1ns/1ps
`default_nettype none

module tb_mm_scheduler;

  localparam int unsigned IterW = mm_sched_pkg::ITER_W;

  // Job shapes; one X column per pass and Height weight rows make one X drain per block
  localparam int unsigned AXRows = 2;
  localparam int unsigned AWCols = 2;
  localparam int unsigned AWRows = 4;
  localparam int unsigned BXRows = 1;
  localparam int unsigned BWCols = 3;
  localparam int unsigned BWRows = 4;
  localparam int unsigned CXRows = 3;
  localparam int unsigned CWCols = 1;
  localparam int unsigned CWRows = 4;

  function automatic int unsigned job_budget(input int unsigned xr, input int unsigned wc,
                                             input int unsigned wr);
    return 4 * xr * wc * wr * (mm_sched_pkg::PIPE_REGS + 2);
  endfunction

  // Shape A runs five times over all tests, B and C once each
  localparam int unsigned CycleLimit = 5 * job_budget(AXRows, AWCols, AWRows) +
                                       job_budget(BXRows, BWCols, BWRows) +
                                       job_budget(CXRows, CWCols, CWRows) + 200;

  logic             clk_i, rst_ni, clear_i, sched_rst_i, first_load_i;
  logic             x_valid_i, w_valid_i, x_full_i, x_empty_i, z_loaded_i, z_empty_i;
  logic             y_enable_i;
  logic [IterW-1:0] x_cols_iters_i, x_rows_iters_i, w_cols_iters_i, w_rows_iters_i;
  logic             reg_enable_o, w_loaded_o, accumulate_o, x_load_o, x_h_shift_o;
  logic             x_pad_setup_o, x_rst_w_index_o, x_last_o, w_load_o, w_shift_o;
  logic             y_push_enable_o, z_fill_o, z_first_load_o;

  logic [12:0] out_vec;
  logic [3:0]  step_vec;
  logic [2:0]  idx_hist = '0;
  logic [15:0] lfsr_q = 16'd65082;
  logic        cnt_clr = 1'b0;
  logic        idle_phase = 1'b1;
  logic        quiet_phase = 1'b0;
  int unsigned load_cnt = 0;
  int unsigned last_cnt = 0;
  int unsigned load_target = 0;
  int unsigned cycle_cnt = 0;
  int unsigned err_cnt = 0;
  int unsigned err_at_start = 0;
  int unsigned test_cnt = 0;
  int unsigned fail_cnt = 0;
  string       cur_test = "reset";

  mm_scheduler #(
    .Height      (mm_sched_pkg::ARRAY_HEIGHT),
    .Depth       (mm_sched_pkg::TOT_DEPTH),
    .NumPipeRegs (mm_sched_pkg::PIPE_REGS)
  ) u_dut (
    .clk_i, .rst_ni, .clear_i, .sched_rst_i, .first_load_i,
    .x_valid_i, .w_valid_i, .x_full_i, .x_empty_i, .z_loaded_i, .z_empty_i, .y_enable_i,
    .x_cols_iters_i, .x_rows_iters_i, .w_cols_iters_i, .w_rows_iters_i,
    .reg_enable_o, .w_loaded_o, .accumulate_o, .x_load_o, .x_h_shift_o, .x_pad_setup_o,
    .x_rst_w_index_o, .x_last_o, .w_load_o, .w_shift_o, .y_push_enable_o, .z_fill_o,
    .z_first_load_o
  );

  assign out_vec  = {reg_enable_o, w_loaded_o, accumulate_o, x_load_o, x_h_shift_o,
                     x_pad_setup_o, x_rst_w_index_o, x_last_o, w_load_o, w_shift_o,
                     y_push_enable_o, z_fill_o, z_first_load_o};
  assign step_vec = {w_load_o, w_loaded_o, x_h_shift_o, w_shift_o};

  always #5 clk_i = ~clk_i;

  // Taps 16, 14, 13 and 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // W stream validity is random, and X drains a few cycles after each weight block ends
  always @(negedge clk_i) begin
    lfsr_q    = lfsr_next(lfsr_q);
    w_valid_i = lfsr_q[0];
    x_empty_i = idx_hist[2];
  end

  always @(posedge clk_i) begin
    if (cnt_clr) begin
      load_cnt <= 0;
      last_cnt <= 0;
    end else begin
      if (w_load_o) load_cnt <= load_cnt + 1;
      if (x_last_o) last_cnt <= last_cnt + 1;
    end
    idx_hist <= {idx_hist[1:0], x_rst_w_index_o};
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CycleLimit) begin
      $display("timeout after %0d cycles in test %s, FSM state %s", cycle_cnt, cur_test,
               u_dut.u_fsm.state_q.name());
      $display("TB FAILED");
      $finish;
    end
  end

  task automatic note_error(input string chk, input int unsigned exp, input int unsigned act);
    err_cnt++;
    $display("error in %s (%s): expected %0d, actual %0d", cur_test, chk, exp, act);
  endtask

  idle_outputs_chk: assert property (@(posedge clk_i) disable iff (!rst_ni)
    idle_phase |-> out_vec == '0)
    else note_error("outputs before start", 0, $sampled(out_vec));

  y_wait_chk: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (y_enable_i && !z_loaded_i) |-> !w_load_o)
    else note_error("w_load_o while Z not loaded", 0, 1);

  w_gap_chk: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (!w_valid_i && load_cnt < load_target) |-> !(w_load_o || w_loaded_o))
    else note_error("W load without valid", 0, $sampled({w_load_o, w_loaded_o}));

  quiet_chk: assert property (@(posedge clk_i) disable iff (!rst_ni)
    quiet_phase |-> step_vec == '0)
    else note_error("step after scheduler reset", 0, $sampled(step_vec));

  last_once_chk: assert property (@(posedge clk_i) disable iff (!rst_ni)
    x_last_o |-> last_cnt == 0)
    else note_error("x_last_o pulses in one job", 0, $sampled(last_cnt));

  task automatic begin_test(input string name);
    cur_test     = name;
    err_at_start = err_cnt;
    test_cnt++;
  endtask

  task automatic end_test();
    if (err_cnt == err_at_start) begin
      $display("test %s: ok", cur_test);
    end else begin
      fail_cnt++;
      $display("test %s: failed", cur_test);
    end
  endtask

  task automatic wait_cycles(input int unsigned n);
    repeat (n) @(negedge clk_i);
  endtask

  // Called on a falling edge; the counts stay stable while first_load_i is high
  task automatic start_job(input int unsigned xr, input int unsigned wc, input int unsigned wr);
    x_cols_iters_i = IterW'(1);
    x_rows_iters_i = IterW'(xr);
    w_cols_iters_i = IterW'(wc);
    w_rows_iters_i = IterW'(wr);
    load_target    = xr * wc * wr;
    cnt_clr        = 1'b1;
    @(negedge clk_i);
    cnt_clr      = 1'b0;
    first_load_i = 1'b1;
    @(negedge clk_i);
    first_load_i = 1'b0;
  endtask

  // The engine enable drops once the FSM is back in IDLE after the last weight load
  task automatic wait_job_end();
    while (!(load_cnt >= load_target && !reg_enable_o)) begin
      @(negedge clk_i);
    end
  endtask

  task automatic close_job();
    wait_cycles(6);
    sched_rst_i = 1'b1;
    @(negedge clk_i);
    sched_rst_i = 1'b0;
  endtask

  task automatic run_full_job(input int unsigned xr, input int unsigned wc,
                              input int unsigned wr, output int unsigned loads,
                              output int unsigned lasts);
    start_job(xr, wc, wr);
    wait_job_end();
    wait_cycles(2);
    loads = load_cnt;
    lasts = last_cnt;
    close_job();
  endtask

  initial begin
    int unsigned loads;
    int unsigned lasts;
    int unsigned first_loads;
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    clear_i        = 1'b0;
    sched_rst_i    = 1'b0;
    first_load_i   = 1'b0;
    x_valid_i      = 1'b1;
    w_valid_i      = 1'b0;
    x_full_i       = 1'b1;
    x_empty_i      = 1'b0;
    z_loaded_i     = 1'b1;
    z_empty_i      = 1'b0;
    y_enable_i     = 1'b0;
    x_cols_iters_i = IterW'(1);
    x_rows_iters_i = IterW'(1);
    w_cols_iters_i = IterW'(1);
    w_rows_iters_i = IterW'(1);
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;

    begin_test("reset_idle");
    wait_cycles(20);
    idle_phase = 1'b0;
    end_test();

    // PRELOAD has to hold until Z reports loaded
    begin_test("y_preload_wait");
    y_enable_i = 1'b1;
    z_loaded_i = 1'b0;
    start_job(AXRows, AWCols, AWRows);
    wait_cycles(30);
    assert (load_cnt == 0) else note_error("loads before Z loaded", 0, load_cnt);
    z_loaded_i = 1'b1;
    wait_job_end();
    assert (load_cnt == load_target) else note_error("w_load_o count", load_target, load_cnt);
    y_enable_i = 1'b0;
    close_job();
    end_test();

    begin_test("job_repeat");
    run_full_job(AXRows, AWCols, AWRows, first_loads, lasts);
    assert (first_loads == AXRows * AWCols * AWRows)
      else note_error("first w_load_o count", AXRows * AWCols * AWRows, first_loads);
    assert (lasts == 1) else note_error("first x_last_o count", 1, lasts);
    run_full_job(AXRows, AWCols, AWRows, loads, lasts);
    assert (loads == first_loads) else note_error("second w_load_o count", first_loads, loads);
    assert (lasts == 1) else note_error("second x_last_o count", 1, lasts);
    end_test();

    begin_test("w_valid_gaps");
    run_full_job(BXRows, BWCols, BWRows, loads, lasts);
    assert (loads == BXRows * BWCols * BWRows)
      else note_error("w_load_o count", BXRows * BWCols * BWRows, loads);
    end_test();

    begin_test("x_last_once");
    run_full_job(CXRows, CWCols, CWRows, loads, lasts);
    assert (lasts == 1) else note_error("x_last_o count", 1, lasts);
    assert (loads == CXRows * CWCols * CWRows)
      else note_error("w_load_o count", CXRows * CWCols * CWRows, loads);
    end_test();

    // Abort a running job, then check that nothing steps until the next start
    begin_test("sched_rst_quiet");
    start_job(AXRows, AWCols, AWRows);
    while (load_cnt < 3) begin
      @(negedge clk_i);
    end
    sched_rst_i = 1'b1;
    @(negedge clk_i);
    sched_rst_i = 1'b0;
    quiet_phase = 1'b1;
    cnt_clr     = 1'b1;
    @(negedge clk_i);
    cnt_clr = 1'b0;
    wait_cycles(40);
    assert (load_cnt == 0) else note_error("loads after scheduler reset", 0, load_cnt);
    quiet_phase = 1'b0;
    run_full_job(AXRows, AWCols, AWRows, loads, lasts);
    assert (loads == AXRows * AWCols * AWRows)
      else note_error("w_load_o count after restart", AXRows * AWCols * AWRows, loads);
    end_test();

    $display("tests run %0d, tests failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdl/mm_scheduler.sv ====
// Top level of the systolic matrix-multiply control scheduler
// Connects configuration capture, FSM, X and W trackers and the result drain tracker

`timescale 1ns/1ps
`default_nettype none

module mm_scheduler #(
  parameter int unsigned Height      = mm_sched_pkg::ARRAY_HEIGHT,
  parameter int unsigned Depth       = mm_sched_pkg::TOT_DEPTH,
  parameter int unsigned NumPipeRegs = mm_sched_pkg::PIPE_REGS
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            clear_i,
  input  logic                            sched_rst_i,
  input  logic                            first_load_i,
  input  logic                            x_valid_i,
  input  logic                            w_valid_i,
  input  logic                            x_full_i,
  input  logic                            x_empty_i,
  input  logic                            z_loaded_i,
  input  logic                            z_empty_i,
  input  logic                            y_enable_i,
  input  logic [mm_sched_pkg::ITER_W-1:0] x_cols_iters_i,
  input  logic [mm_sched_pkg::ITER_W-1:0] x_rows_iters_i,
  input  logic [mm_sched_pkg::ITER_W-1:0] w_cols_iters_i,
  input  logic [mm_sched_pkg::ITER_W-1:0] w_rows_iters_i,
  output logic                            reg_enable_o,
  output logic                            w_loaded_o,
  output logic                            accumulate_o,
  output logic                            x_load_o,
  output logic                            x_h_shift_o,
  output logic                            x_pad_setup_o,
  output logic                            x_rst_w_index_o,
  output logic                            x_last_o,
  output logic                            w_load_o,
  output logic                            w_shift_o,
  output logic                            y_push_enable_o,
  output logic                            z_fill_o,
  output logic                            z_first_load_o
);

  logic                            start, step, adv, pad_setup, first_step;
  logic                            x_done, x_shift_wrap, w_done, w_col_wrap;
  logic                            y_check, z_last, y_pushing;
  logic [mm_sched_pkg::ITER_W-1:0] x_cols_last, x_rows_last, w_cols_last, w_rows_last;

  sched_config u_config (
    .clk_i, .rst_ni, .clear_i, .sched_rst_i,
    .start_i        (start),
    .x_cols_iters_i, .x_rows_iters_i, .w_cols_iters_i, .w_rows_iters_i,
    .x_cols_last_o  (x_cols_last),
    .x_rows_last_o  (x_rows_last),
    .w_cols_last_o  (w_cols_last),
    .w_rows_last_o  (w_rows_last)
  );

  sched_fsm #(.NumPipeRegs(NumPipeRegs)) u_fsm (
    .clk_i, .rst_ni, .clear_i, .sched_rst_i, .first_load_i, .y_enable_i,
    .x_full_i, .x_empty_i, .z_loaded_i, .w_valid_i,
    .x_done_i (x_done), .x_shift_wrap_i (x_shift_wrap), .w_done_i (w_done),
    .y_check_i (y_check), .z_last_i (z_last), .y_pushing_i (y_pushing),
    .start_o (start), .step_o (step), .adv_o (adv), .pad_setup_o (pad_setup),
    .computing_o (), .first_step_o (first_step),
    .reg_enable_o, .w_loaded_o, .accumulate_o
  );

  x_iter_ctrl #(.Height(Height)) u_x_iter (
    .clk_i, .rst_ni, .clear_i, .sched_rst_i,
    .start_i (start), .step_i (step), .pad_setup_i (pad_setup),
    .x_valid_i, .x_full_i, .x_empty_i,
    .x_cols_last_i (x_cols_last), .x_rows_last_i (x_rows_last), .w_cols_last_i (w_cols_last),
    .x_load_o, .x_h_shift_o, .x_pad_setup_o, .x_rst_w_index_o, .x_last_o,
    .x_done_o (x_done), .x_shift_wrap_o (x_shift_wrap)
  );

  w_iter_ctrl u_w_iter (
    .clk_i, .rst_ni, .clear_i, .sched_rst_i,
    .step_i (step), .adv_i (adv),
    .w_rows_last_i (w_rows_last), .w_cols_last_i (w_cols_last), .x_rows_last_i (x_rows_last),
    .w_load_o, .w_shift_o, .w_col_wrap_o (w_col_wrap), .w_done_o (w_done)
  );

  z_drain_ctrl #(.Depth(Depth), .NumPipeRegs(NumPipeRegs)) u_z_drain (
    .clk_i, .rst_ni, .clear_i, .sched_rst_i,
    .adv_i (adv), .first_step_i (first_step), .reg_enable_i (reg_enable_o),
    .w_col_wrap_i (w_col_wrap), .z_empty_i,
    .w_cols_last_i (w_cols_last), .w_rows_last_i (w_rows_last),
    .y_push_enable_o, .z_fill_o, .z_first_load_o,
    .y_check_o (y_check), .z_last_o (z_last), .y_pushing_o (y_pushing)
  );

endmodule

`default_nettype wire

// ==== hdl/z_drain_ctrl.sv ====
// Result drain tracker
// Chains the pipeline wait, the Z availability window and the Y push window per W column

`timescale 1ns/1ps
`default_nettype none

module z_drain_ctrl #(
  parameter int unsigned Depth       = mm_sched_pkg::TOT_DEPTH,
  parameter int unsigned NumPipeRegs = mm_sched_pkg::PIPE_REGS
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            clear_i,
  input  logic                            sched_rst_i,
  input  logic                            adv_i,
  input  logic                            first_step_i,
  input  logic                            reg_enable_i,
  input  logic                            w_col_wrap_i,
  input  logic                            z_empty_i,
  input  logic [mm_sched_pkg::ITER_W-1:0] w_cols_last_i,
  input  logic [mm_sched_pkg::ITER_W-1:0] w_rows_last_i,
  output logic                            y_push_enable_o,
  output logic                            z_fill_o,
  output logic                            z_first_load_o,
  output logic                            y_check_o,
  output logic                            z_last_o,
  output logic                            y_pushing_o
);

  localparam int unsigned WaitW = (NumPipeRegs > 0) ? $clog2(NumPipeRegs + 1) : 1;
  localparam int unsigned DepW  = (Depth > 1) ? $clog2(Depth) : 1;
  localparam logic [WaitW-1:0] WaitLast = WaitW'(NumPipeRegs);
  localparam logic [WaitW-1:0] WaitPre  = WaitW'(NumPipeRegs - 1);
  localparam logic [DepW-1:0]  DepLast  = DepW'(Depth - 1);

  logic                            clr;
  logic                            wait_en_q, avail_en_q, push_en_q, pushing_q;
  logic [WaitW-1:0]                wait_q;
  logic [DepW-1:0]                 avail_q, push_q;
  logic                            wait_step, wait_clr, avail_step, avail_clr;
  logic                            push_step, push_clr, push_set, ycol_wrap;
  logic [mm_sched_pkg::ITER_W-1:0] ycols_q, yrows_q;

  assign clr = clear_i | sched_rst_i;

  // All three windows advance only while the array advances
  assign wait_step  = wait_en_q & adv_i;
  assign wait_clr   = wait_step & (wait_q == WaitLast);
  assign avail_step = avail_en_q & adv_i;
  assign avail_clr  = avail_step & (avail_q == DepLast);
  assign push_step  = push_en_q & adv_i;
  assign push_clr   = push_step & (push_q == DepLast);
  // Y rows go in one cycle ahead of the results so the first tile starts at the first step
  assign push_set   = (wait_step & (wait_q == WaitPre)) | first_step_i;
  assign ycol_wrap  = z_empty_i & (ycols_q == w_cols_last_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wait_en_q  <= 1'b0;
      avail_en_q <= 1'b0;
      push_en_q  <= 1'b0;
      pushing_q  <= 1'b0;
      wait_q     <= '0;
      avail_q    <= '0;
      push_q     <= '0;
      ycols_q    <= '0;
      yrows_q    <= '0;
    end else if (clr) begin
      wait_en_q  <= 1'b0;
      avail_en_q <= 1'b0;
      push_en_q  <= 1'b0;
      pushing_q  <= 1'b0;
      wait_q     <= '0;
      avail_q    <= '0;
      push_q     <= '0;
      ycols_q    <= '0;
      yrows_q    <= '0;
    end else begin
      wait_en_q  <= w_col_wrap_i | (wait_en_q & ~wait_clr);
      avail_en_q <= wait_clr | (avail_en_q & ~avail_clr);
      push_en_q  <= push_set | (push_en_q & ~push_clr);
      pushing_q  <= push_en_q;
      if (wait_step) wait_q <= wait_clr ? '0 : wait_q + 1'b1;
      if (avail_step) avail_q <= avail_clr ? '0 : avail_q + 1'b1;
      if (push_step) push_q <= push_clr ? '0 : push_q + 1'b1;
      if (z_empty_i) ycols_q <= ycol_wrap ? '0 : ycols_q + 1'b1;
      if (ycol_wrap) yrows_q <= (yrows_q == w_rows_last_i) ? '0 : yrows_q + 1'b1;
    end
  end

  assign y_push_enable_o = push_step;
  assign z_fill_o        = avail_en_q & reg_enable_i;
  assign z_first_load_o  = reg_enable_i & (ycols_q == '0) & (yrows_q == '0);
  assign y_check_o       = wait_q == WaitLast;
  assign z_last_o        = avail_clr;
  assign y_pushing_o     = pushing_q;

endmodule

`default_nettype wire

// ==== hdl/sched_fsm.sv ====
// Main scheduler FSM with the stall checks and the engine enable register
// Walks IDLE, PRELOAD, LOAD_W and WAIT, and freezes the array when an operand is missing

`timescale 1ns/1ps
`default_nettype none

module sched_fsm #(
  parameter int unsigned NumPipeRegs = mm_sched_pkg::PIPE_REGS
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic clear_i,
  input  logic sched_rst_i,
  input  logic first_load_i,
  input  logic y_enable_i,
  input  logic x_full_i,
  input  logic x_empty_i,
  input  logic z_loaded_i,
  input  logic w_valid_i,
  input  logic x_done_i,
  input  logic x_shift_wrap_i,
  input  logic w_done_i,
  input  logic y_check_i,
  input  logic z_last_i,
  input  logic y_pushing_i,
  output logic start_o,
  output logic step_o,
  output logic adv_o,
  output logic pad_setup_o,
  output logic computing_o,
  output logic first_step_o,
  output logic reg_enable_o,
  output logic w_loaded_o,
  output logic accumulate_o
);

  localparam int unsigned CntW = (NumPipeRegs > 0) ? $clog2(NumPipeRegs + 1) : 1;
  localparam logic [CntW-1:0] CntLast = CntW'(NumPipeRegs);

  mm_sched_pkg::sched_state_e state_q, state_d;
  logic            clr, stall, in_load, job_end, x_index_rst;
  logic [CntW-1:0] wait_cnt_q;
  logic            computing_q, first_load_q, x_refill_q, reg_enable_q;

  assign clr     = clear_i | sched_rst_i;
  assign in_load = state_q == mm_sched_pkg::LOAD_W;

  // Checks only apply in LOAD_W; the X check is armed when a refill meets the shift wrap
  assign stall = in_load & ((~w_valid_i & ~w_done_i) |
                            (~x_full_i & x_refill_q & x_shift_wrap_i & ~x_done_i) |
                            (~z_loaded_i & y_check_i & ~w_done_i));

  assign start_o      = (state_q == mm_sched_pkg::IDLE) & first_load_i;
  assign step_o       = in_load & ~stall;
  assign adv_o        = (in_load | (state_q == mm_sched_pkg::WAIT)) & ~stall;
  assign pad_setup_o  = (state_q == mm_sched_pkg::PRELOAD) & (state_d == mm_sched_pkg::LOAD_W);
  assign first_step_o = first_load_q & (state_d == mm_sched_pkg::LOAD_W) & ~stall;
  assign job_end      = in_load & w_done_i & z_last_i;
  assign x_index_rst  = step_o & x_shift_wrap_i & x_full_i;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      mm_sched_pkg::IDLE: begin
        if (first_load_i) state_d = mm_sched_pkg::PRELOAD;
      end
      // Y is only waited for when the job accumulates onto it
      mm_sched_pkg::PRELOAD: begin
        if (x_full_i && (z_loaded_i || !y_enable_i)) state_d = mm_sched_pkg::LOAD_W;
      end
      mm_sched_pkg::LOAD_W: begin
        if (job_end) begin
          state_d = mm_sched_pkg::IDLE;
        end else if (!stall) begin
          state_d = mm_sched_pkg::WAIT;
        end
      end
      default: begin
        if (wait_cnt_q == CntLast) state_d = mm_sched_pkg::LOAD_W;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= mm_sched_pkg::IDLE;
      wait_cnt_q <= '0;
    end else if (clr) begin
      state_q    <= mm_sched_pkg::IDLE;
      wait_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (job_end) begin
        wait_cnt_q <= '0;
      end else if (adv_o) begin
        wait_cnt_q <= (wait_cnt_q == CntLast) ? '0 : wait_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      computing_q  <= 1'b0;
      first_load_q <= 1'b0;
      x_refill_q   <= 1'b0;
      reg_enable_q <= 1'b0;
    end else if (clr) begin
      computing_q  <= 1'b0;
      first_load_q <= 1'b0;
      x_refill_q   <= 1'b0;
      reg_enable_q <= 1'b0;
    end else begin
      computing_q  <= ~job_end & (computing_q | pad_setup_o);
      first_load_q <= start_o | (first_load_q & ~step_o);
      x_refill_q   <= ~x_index_rst & (x_refill_q | x_empty_i);
      reg_enable_q <= computing_q & ~stall;
    end
  end

  assign computing_o  = computing_q;
  assign reg_enable_o = reg_enable_q;
  assign w_loaded_o   = step_o;
  assign accumulate_o = computing_q & ~y_pushing_i;

endmodule

`default_nettype wire

// ==== hdl/w_iter_ctrl.sv ====
// W-buffer iteration tracker
// Counts weight rows, columns and matrix passes per step and raises W-done after the last pass

`timescale 1ns/1ps
`default_nettype none

module w_iter_ctrl (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            clear_i,
  input  logic                            sched_rst_i,
  input  logic                            step_i,
  input  logic                            adv_i,
  input  logic [mm_sched_pkg::ITER_W-1:0] w_rows_last_i,
  input  logic [mm_sched_pkg::ITER_W-1:0] w_cols_last_i,
  input  logic [mm_sched_pkg::ITER_W-1:0] x_rows_last_i,
  output logic                            w_load_o,
  output logic                            w_shift_o,
  output logic                            w_col_wrap_o,
  output logic                            w_done_o
);

  logic                            clr;
  logic [mm_sched_pkg::ITER_W-1:0] rows_q, cols_q, mat_q;
  logic                            rows_en, cols_en, mat_en, done_en, done_q;

  assign clr = clear_i | sched_rst_i;

  // Once every pass is loaded the counters freeze and further steps only shift
  assign rows_en = step_i & ~done_q;
  assign cols_en = rows_en & (rows_q == w_rows_last_i);
  assign mat_en  = cols_en & (cols_q == w_cols_last_i);
  assign done_en = mat_en & (mat_q == x_rows_last_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rows_q <= '0;
      cols_q <= '0;
      mat_q  <= '0;
      done_q <= 1'b0;
    end else if (clr) begin
      rows_q <= '0;
      cols_q <= '0;
      mat_q  <= '0;
      done_q <= 1'b0;
    end else if (rows_en) begin
      rows_q <= cols_en ? '0 : rows_q + 1'b1;
      if (cols_en) begin
        cols_q <= mat_en ? '0 : cols_q + 1'b1;
      end
      if (mat_en) begin
        mat_q <= mat_q + 1'b1;
      end
      done_q <= done_en;
    end
  end

  assign w_load_o     = rows_en;
  assign w_shift_o    = adv_i;
  assign w_col_wrap_o = cols_en;
  assign w_done_o     = done_q;

endmodule

`default_nettype wire

// ==== hdl/x_iter_ctrl.sv ====
// X-buffer iteration tracker
// Counts drained X columns, weight passes and rows, and drives the X reload and shift controls

`timescale 1ns/1ps
`default_nettype none

module x_iter_ctrl #(
  parameter int unsigned Height = mm_sched_pkg::ARRAY_HEIGHT
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            clear_i,
  input  logic                            sched_rst_i,
  input  logic                            start_i,
  input  logic                            step_i,
  input  logic                            pad_setup_i,
  input  logic                            x_valid_i,
  input  logic                            x_full_i,
  input  logic                            x_empty_i,
  input  logic [mm_sched_pkg::ITER_W-1:0] x_cols_last_i,
  input  logic [mm_sched_pkg::ITER_W-1:0] x_rows_last_i,
  input  logic [mm_sched_pkg::ITER_W-1:0] w_cols_last_i,
  output logic                            x_load_o,
  output logic                            x_h_shift_o,
  output logic                            x_pad_setup_o,
  output logic                            x_rst_w_index_o,
  output logic                            x_last_o,
  output logic                            x_done_o,
  output logic                            x_shift_wrap_o
);

  localparam int unsigned ShiftW = (Height > 1) ? $clog2(Height) : 1;
  localparam logic [ShiftW-1:0] ShiftLast = ShiftW'(Height - 1);

  logic                            clr;
  logic [mm_sched_pkg::ITER_W-1:0] cols_q, pass_q, rows_q;
  logic                            pass_en, rows_en, done_en, done_q;
  logic [ShiftW-1:0]               shift_q;
  logic                            shift_wrap;
  logic                            reload_q, reload_en, reload_rst, empty_seen_q;

  assign clr = clear_i | sched_rst_i;

  // The empty flag is a single-cycle pulse, so each pulse is one drained column
  assign pass_en = x_empty_i & (cols_q == x_cols_last_i);
  assign rows_en = pass_en & (pass_q == w_cols_last_i);
  assign done_en = rows_en & (rows_q == x_rows_last_i) & ~done_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cols_q <= '0;
      pass_q <= '0;
      rows_q <= '0;
      done_q <= 1'b0;
    end else if (clr || start_i) begin
      cols_q <= '0;
      pass_q <= '0;
      rows_q <= '0;
      done_q <= 1'b0;
    end else if (!done_q && x_empty_i) begin
      cols_q <= pass_en ? '0 : cols_q + 1'b1;
      if (pass_en) begin
        pass_q <= rows_en ? '0 : pass_q + 1'b1;
      end
      if (rows_en) begin
        rows_q <= rows_q + 1'b1;
      end
      done_q <= done_en;
    end
  end

  assign shift_wrap = shift_q == ShiftLast;

  // A reload is pending from job start or a drained column until the buffer reports full
  assign reload_en  = start_i | x_empty_i | (empty_seen_q & ~x_full_i);
  assign reload_rst = x_full_i & ~reload_en;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shift_q      <= '0;
      reload_q     <= 1'b0;
      empty_seen_q <= 1'b0;
    end else if (clr) begin
      shift_q      <= '0;
      reload_q     <= 1'b0;
      empty_seen_q <= 1'b0;
    end else begin
      if (start_i) begin
        shift_q <= '0;
      end else if (step_i) begin
        shift_q <= shift_wrap ? '0 : shift_q + 1'b1;
      end
      reload_q     <= reload_en | (reload_q & ~reload_rst);
      empty_seen_q <= x_full_i & (empty_seen_q | x_empty_i);
    end
  end

  assign x_load_o        = reload_q & ~reload_rst & x_valid_i;
  assign x_h_shift_o     = step_i;
  assign x_pad_setup_o   = pad_setup_i;
  assign x_rst_w_index_o = step_i & shift_wrap & x_full_i;
  assign x_last_o        = done_en;
  assign x_done_o        = done_q;
  assign x_shift_wrap_o  = shift_wrap;

endmodule

`default_nettype wire

// ==== hdl/sched_config.sv ====
// Job configuration capture for the scheduler
// Latches each iteration count minus one on the start pulse and holds it for the whole job

`timescale 1ns/1ps
`default_nettype none

module sched_config (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            clear_i,
  input  logic                            sched_rst_i,
  input  logic                            start_i,
  input  logic [mm_sched_pkg::ITER_W-1:0] x_cols_iters_i,
  input  logic [mm_sched_pkg::ITER_W-1:0] x_rows_iters_i,
  input  logic [mm_sched_pkg::ITER_W-1:0] w_cols_iters_i,
  input  logic [mm_sched_pkg::ITER_W-1:0] w_rows_iters_i,
  output logic [mm_sched_pkg::ITER_W-1:0] x_cols_last_o,
  output logic [mm_sched_pkg::ITER_W-1:0] x_rows_last_o,
  output logic [mm_sched_pkg::ITER_W-1:0] w_cols_last_o,
  output logic [mm_sched_pkg::ITER_W-1:0] w_rows_last_o
);

  logic clr;

  assign clr = clear_i | sched_rst_i;

  // Counts are at least 1, so the terminal value never underflows
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      x_cols_last_o <= '0;
      x_rows_last_o <= '0;
      w_cols_last_o <= '0;
      w_rows_last_o <= '0;
    end else if (clr) begin
      x_cols_last_o <= '0;
      x_rows_last_o <= '0;
      w_cols_last_o <= '0;
      w_rows_last_o <= '0;
    end else if (start_i) begin
      x_cols_last_o <= x_cols_iters_i - 1'b1;
      x_rows_last_o <= x_rows_iters_i - 1'b1;
      w_cols_last_o <= w_cols_iters_i - 1'b1;
      w_rows_last_o <= w_rows_iters_i - 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/mm_sched_pkg.sv ====
// Shared types and default dimensions for the matrix-multiply scheduler
// Modules reference these by scoped name; the top level turns the defaults into parameters

`default_nettype none

package mm_sched_pkg;

  // Main FSM states of the scheduler
  typedef enum logic [1:0] {
    IDLE,
    PRELOAD,
    LOAD_W,
    WAIT
  } sched_state_e;

  // Width of every iteration count and iteration counter
  localparam int unsigned ITER_W = 16;

  // X shift steps per weight block
  localparam int unsigned ARRAY_HEIGHT = 4;

  // Z rows pushed and drained per result tile
  localparam int unsigned TOT_DEPTH = 8;

  // Extra cycles an engine column needs before its result is valid
  localparam int unsigned PIPE_REGS = 3;

endpackage

`default_nettype wire
